// File: dbg_pkg.sv
`default_nettype none

package dbg_pkg;

    localparam int WORD_W       = 32;
    localparam int BYTE_W       = 8;
    localparam int IMEM_ADDR_W  = 8;
    localparam int IMEM_DEPTH   = 256;
    localparam int CLKS_PER_BIT = 16;                   // baud divider
    localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [BYTE_W-1:0]      byte_t;
    typedef logic [IMEM_ADDR_W-1:0] imem_addr_t;

    // host commands, first character in the top byte
    localparam word_t CMD_CHARGE = {8'h00, "chm"};
    localparam word_t CMD_CONT   = {8'h00, "com"};
    localparam word_t CMD_STEP   = {8'h00, "stm"};
    localparam word_t CMD_NEXT   = "nxst";
    localparam word_t CMD_CANCEL = "clst";
    localparam word_t END_INSTR  = 32'hFFFF_FFFF;      // closes a load, never stored

    typedef logic [63:0]  if_id_t;
    typedef logic [138:0] id_ex_t;
    typedef logic [75:0]  ex_mem_t;
    typedef logic [70:0]  mem_wb_t;

    typedef struct packed {
        if_id_t  if_id;     // sent first
        id_ex_t  id_ex;
        ex_mem_t ex_mem;
        mem_wb_t mem_wb;
    } pipe_latches_t;

    // 350 latch bits padded with zeros on top to a whole number of bytes
    localparam int DUMP_BYTES = 44;
    typedef logic [DUMP_BYTES*BYTE_W-1:0] dump_frame_t;

    typedef enum logic [2:0] {
        GEN_IDLE,
        LOAD_WAIT,
        LOAD_WRITE,
        RUN_CONT,
        STEP_WAIT,
        STEP_DECODE,
        STEP_EXEC,
        DUMP
    } dbg_state_t;

    typedef struct packed {
        logic       en;
        imem_addr_t addr;
        word_t      data;
    } imem_wr_t;

endpackage

`default_nettype wire

// File: uart_rx.sv
`default_nettype none

module uart_rx
    import dbg_pkg::*;
(
    input  wire   i_clk,
    input  wire   i_reset,
    input  wire   i_rx,
    output byte_t o_byte,
    output logic  o_byte_valid
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t             state;
    logic [1:0]            rx_sync;     // line comes from outside the clock domain
    logic                  rx_s;
    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [2:0]            bit_idx;
    byte_t                 shreg;

    assign rx_s   = rx_sync[1];
    assign o_byte = shreg;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state        <= RX_IDLE;
            rx_sync      <= 2'b11;
            baud_cnt     <= '0;
            bit_idx      <= '0;
            o_byte_valid <= 1'b0;
        end else begin
            rx_sync      <= {rx_sync[0], i_rx};
            o_byte_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (!rx_s) state <= RX_START;   // falling edge of start bit
                end
                RX_START: begin
                    if (baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT/2 - 1)) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        // a start bit that went high again was a glitch
                        state    <= rx_s ? RX_IDLE : RX_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1)) begin
                        baud_cnt <= '0;
                        shreg    <= {rx_s, shreg[BYTE_W-1:1]};     // lsb arrives first
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1)) begin
                        baud_cnt     <= '0;
                        o_byte_valid <= rx_s;   // bad stop bit drops the byte
                        state        <= RX_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // a strobe per frame, frames are far longer than a cycle
    a_single_strobe: assert property (@(posedge i_clk) disable iff (i_reset)
        o_byte_valid |=> !o_byte_valid);

endmodule

`default_nettype wire

// File: uart_tx.sv
`default_nettype none

module uart_tx
    import dbg_pkg::*;
(
    input  wire   i_clk,
    input  wire   i_reset,
    input  wire   byte_t i_byte,
    input  wire   i_send,
    output logic  o_tx,
    output logic  o_busy
);

    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [3:0]            bit_cnt;     // 0 start, 1..8 data, 9 stop
    byte_t                 shreg;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_tx     <= 1'b1;
            o_busy   <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!o_busy) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            if (i_send) begin
                o_busy <= 1'b1;
                o_tx   <= 1'b0;     // start bit
                shreg  <= i_byte;
            end
        end else if (baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1)) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd9) begin
                o_busy <= 1'b0;     // end of stop bit
                o_tx   <= 1'b1;
            end else if (bit_cnt == 4'd8) begin
                o_tx <= 1'b1;
            end else begin
                o_tx  <= shreg[0];
                shreg <= shreg >> 1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // sender has to wait out the whole frame
    a_no_send_busy: assert property (@(posedge i_clk) disable iff (i_reset)
        i_send |-> !o_busy);

endmodule

`default_nettype wire

// File: word_assembler.sv
`default_nettype none

module word_assembler
    import dbg_pkg::*;
(
    input  wire   i_clk,
    input  wire   i_reset,
    input  wire   byte_t i_byte,
    input  wire   i_byte_valid,
    output word_t o_word,
    output logic  o_word_valid
);

    logic [1:0] byte_cnt;   // wraps after the fourth byte

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            byte_cnt     <= '0;
            o_word_valid <= 1'b0;
        end else begin
            o_word_valid <= 1'b0;
            if (i_byte_valid) begin
                // earlier bytes move up, so the first one ends in the top byte
                o_word   <= {o_word[WORD_W-BYTE_W-1:0], i_byte};
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt == 2'd3) o_word_valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: debug_unit.sv
`default_nettype none

module debug_unit
    import dbg_pkg::*;
(
    input  wire      i_clk,
    input  wire      i_reset,
    input  wire      word_t i_data,
    input  wire      i_data_ready,
    input  wire      i_program_end,
    input  wire      i_dump_done,
    output imem_wr_t o_imem_wr,
    output logic     o_dump_start,
    output logic     o_halt,
    output logic     o_pipe_reset
);

    dbg_state_t state;
    logic       loaded;         // a complete program is in imem
    logic       step_session;   // dump ends go back to STEP_WAIT
    imem_addr_t load_addr;
    word_t      cmd_q;          // step command waiting for decode

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state        <= GEN_IDLE;
            loaded       <= 1'b0;
            step_session <= 1'b0;
            load_addr    <= '0;
            o_imem_wr.en <= 1'b0;
            o_dump_start <= 1'b0;
            o_halt       <= 1'b1;       // pipeline frozen until a run
            o_pipe_reset <= 1'b0;
        end else begin
            // pulses last one cycle only
            o_imem_wr.en <= 1'b0;
            o_dump_start <= 1'b0;
            o_pipe_reset <= 1'b0;

            case (state)
                GEN_IDLE: begin
                    o_halt <= 1'b1;
                    if (i_data_ready) begin
                        if (i_data == CMD_CHARGE) begin
                            loaded    <= 1'b0;   // old program is being overwritten
                            load_addr <= '0;
                            state     <= LOAD_WAIT;
                        end else if (i_data == CMD_CONT && loaded) begin
                            state <= RUN_CONT;
                        end else if (i_data == CMD_STEP && loaded) begin
                            step_session <= 1'b1;
                            state        <= STEP_WAIT;
                        end
                    end
                end

                LOAD_WAIT: begin
                    if (i_data_ready) begin
                        if (i_data == END_INSTR) begin
                            loaded       <= 1'b1;
                            o_pipe_reset <= 1'b1;   // pc back to 0 for the new program
                            state        <= GEN_IDLE;
                        end else begin
                            o_imem_wr.en   <= 1'b1;
                            o_imem_wr.addr <= load_addr;
                            o_imem_wr.data <= i_data;
                            load_addr      <= load_addr + 1'b1;
                            state          <= LOAD_WRITE;
                        end
                    end
                end

                LOAD_WRITE: state <= LOAD_WAIT;     // write enable drops here

                RUN_CONT: begin
                    if (i_program_end) begin
                        o_halt       <= 1'b1;
                        o_dump_start <= 1'b1;
                        state        <= DUMP;
                    end else begin
                        o_halt <= 1'b0;
                    end
                end

                STEP_WAIT: begin
                    if (i_data_ready) begin
                        cmd_q <= i_data;
                        state <= STEP_DECODE;
                    end
                end

                STEP_DECODE: begin
                    if (cmd_q == CMD_NEXT) begin
                        o_halt <= 1'b0;     // lets exactly one clock edge through
                        state  <= STEP_EXEC;
                    end else if (cmd_q == CMD_CANCEL) begin
                        o_pipe_reset <= 1'b1;
                        step_session <= 1'b0;
                        state        <= GEN_IDLE;
                    end else begin
                        state <= STEP_WAIT;     // keep waiting past an unknown word
                    end
                end

                STEP_EXEC: begin
                    o_halt       <= 1'b1;
                    o_dump_start <= 1'b1;   // latches now hold the stepped values
                    state        <= DUMP;
                end

                DUMP: begin
                    if (i_dump_done) begin
                        if (!step_session || i_program_end) begin
                            o_pipe_reset <= 1'b1;
                            step_session <= 1'b0;
                            state        <= GEN_IDLE;
                        end else begin
                            state <= STEP_WAIT;
                        end
                    end
                end

                default: state <= GEN_IDLE;
            endcase
        end
    end

    // the pipeline may only advance in a run or in one step cycle
    a_halt_low_states: assert property (@(posedge i_clk) disable iff (i_reset)
        !o_halt |-> (state == RUN_CONT || state == STEP_EXEC));

    a_wr_only_in_load: assert property (@(posedge i_clk) disable iff (i_reset)
        o_imem_wr.en |-> (state == LOAD_WRITE));

endmodule

`default_nettype wire

// File: latch_dumper.sv
`default_nettype none

module latch_dumper
    import dbg_pkg::*;
(
    input  wire   i_clk,
    input  wire   i_reset,
    input  wire   pipe_latches_t i_latches,
    input  wire   i_start,
    input  wire   i_tx_busy,
    output byte_t o_tx_byte,
    output logic  o_tx_send,
    output logic  o_done
);

    dump_frame_t                          snap;    // shifts left as bytes go out
    logic [$clog2(DUMP_BYTES + 1)-1:0]    sent;
    logic                                 active;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            active    <= 1'b0;
            sent      <= '0;
            o_tx_send <= 1'b0;
            o_done    <= 1'b0;
        end else begin
            o_tx_send <= 1'b0;
            o_done    <= 1'b0;
            if (!active) begin
                if (i_start) begin
                    snap   <= dump_frame_t'(i_latches);    // zero-extended on top
                    sent   <= '0;
                    active <= 1'b1;
                end
            end else if (!o_tx_send && !i_tx_busy) begin
                // busy only rises the cycle after a send, so skip that cycle
                if (sent == DUMP_BYTES) begin
                    o_done <= 1'b1;     // last frame has left the line
                    active <= 1'b0;
                end else begin
                    o_tx_byte <= snap[$bits(dump_frame_t)-1 -: BYTE_W];
                    snap      <= snap << BYTE_W;
                    o_tx_send <= 1'b1;
                    sent      <= sent + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: imem_arbiter.sv
`default_nettype none

module imem_arbiter
    import dbg_pkg::*;
(
    input  wire   i_clk,
    input  wire   i_reset,
    input  wire   imem_wr_t i_wr,
    input  wire   imem_addr_t i_fetch_addr,
    input  wire   i_fetch_rd,
    output word_t o_fetch_data,
    output logic  o_fetch_stall
);

    word_t mem [IMEM_DEPTH];
    logic  rd_grant;

    // single port that the loader wins
    assign rd_grant      = i_fetch_rd && !i_wr.en;
    assign o_fetch_stall = i_fetch_rd && i_wr.en;   // fetch retries next cycle

    always_ff @(posedge i_clk) begin
        if (i_wr.en) mem[i_wr.addr] <= i_wr.data;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_fetch_data <= '0;     // fetch sees zero until its first read
        end else if (rd_grant) begin
            o_fetch_data <= mem[i_fetch_addr];
        end
    end

endmodule

`default_nettype wire

// File: debug_top.sv
`default_nettype none

module debug_top
    import dbg_pkg::*;
(
    input  wire   i_clk,
    input  wire   i_reset,
    input  wire   i_rx,
    output logic  o_tx,
    input  wire   i_program_end,
    input  wire   pipe_latches_t i_latches,
    input  wire   imem_addr_t i_fetch_addr,
    input  wire   i_fetch_rd,
    output word_t o_fetch_data,
    output logic  o_fetch_stall,
    output logic  o_halt,
    output logic  o_pipe_reset
);

    byte_t    rx_byte;
    logic     rx_valid;
    word_t    host_word;
    logic     host_word_valid;
    imem_wr_t imem_wr;
    logic     dump_start;
    logic     dump_done;
    byte_t    tx_byte;
    logic     tx_send;
    logic     tx_busy;

    uart_rx u_rx (
        .i_clk(i_clk), .i_reset(i_reset), .i_rx(i_rx),
        .o_byte(rx_byte), .o_byte_valid(rx_valid)
    );

    word_assembler u_asm (
        .i_clk(i_clk), .i_reset(i_reset), .i_byte(rx_byte), .i_byte_valid(rx_valid),
        .o_word(host_word), .o_word_valid(host_word_valid)
    );

    debug_unit u_dbg (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_data(host_word), .i_data_ready(host_word_valid),
        .i_program_end(i_program_end), .i_dump_done(dump_done),
        .o_imem_wr(imem_wr), .o_dump_start(dump_start),
        .o_halt(o_halt), .o_pipe_reset(o_pipe_reset)
    );

    latch_dumper u_dump (
        .i_clk(i_clk), .i_reset(i_reset), .i_latches(i_latches),
        .i_start(dump_start), .i_tx_busy(tx_busy),
        .o_tx_byte(tx_byte), .o_tx_send(tx_send), .o_done(dump_done)
    );

    uart_tx u_tx (
        .i_clk(i_clk), .i_reset(i_reset), .i_byte(tx_byte), .i_send(tx_send),
        .o_tx(o_tx), .o_busy(tx_busy)
    );

    imem_arbiter u_imem (
        .i_clk(i_clk), .i_reset(i_reset), .i_wr(imem_wr),
        .i_fetch_addr(i_fetch_addr), .i_fetch_rd(i_fetch_rd),
        .o_fetch_data(o_fetch_data), .o_fetch_stall(o_fetch_stall)
    );

endmodule

`default_nettype wire

// File: tb_debug_top.sv
`default_nettype none

module tb_debug_top
    import dbg_pkg::*;
();

    logic          i_clk;
    logic          i_reset;
    logic          i_rx;
    logic          o_tx;
    logic          i_program_end;
    pipe_latches_t latches;
    imem_addr_t    i_fetch_addr;
    logic          i_fetch_rd;
    word_t         o_fetch_data;
    logic          o_fetch_stall;
    logic          o_halt;
    logic          o_pipe_reset;

    int    errors = 0;
    int    checks = 0;
    int    pipe_resets = 0;
    int    halt_low_cycles = 0;
    logic  step_mode = 1'b0;
    byte_t rx_bytes[$];     // bytes decoded from o_tx

    debug_top dut0 (
        .i_clk(i_clk), .i_reset(i_reset), .i_rx(i_rx), .o_tx(o_tx),
        .i_program_end(i_program_end), .i_latches(latches),
        .i_fetch_addr(i_fetch_addr), .i_fetch_rd(i_fetch_rd),
        .o_fetch_data(o_fetch_data), .o_fetch_stall(o_fetch_stall),
        .o_halt(o_halt), .o_pipe_reset(o_pipe_reset)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    task automatic report_problem(input string what);
        errors++;
        $display("ERROR: %s", what);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    function automatic pipe_latches_t random_latches();
        logic [351:0] r;
        for (int i = 0; i < 11; i++) r[i*32 +: 32] = $urandom;
        return r[349:0];
    endfunction

    // pipeline model moves its latches only while halt is released
    always @(posedge i_clk) begin
        if (!o_halt) latches <= random_latches();
    end

    always @(posedge i_clk) begin
        if (!i_reset) begin
            if (o_pipe_reset) pipe_resets <= pipe_resets + 1;
            if (!o_halt) halt_low_cycles <= halt_low_cycles + 1;
        end
    end

    // a step lets the pipeline through for one cycle only
    a_step_single_cycle: assert property (@(posedge i_clk) disable iff (i_reset || !step_mode)
        !o_halt |=> o_halt) else begin
        errors++;
        $display("ERROR: halt stayed low for more than one cycle in a step");
    end

    // host side receiver samples o_tx at mid-bit
    initial begin : host_receiver
        byte_t b;
        forever begin
            @(posedge i_clk);
            if (!i_reset && o_tx == 1'b0) begin
                repeat (CLKS_PER_BIT/2) @(posedge i_clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(posedge i_clk);
                    b[i] = o_tx;        // lsb first
                end
                repeat (CLKS_PER_BIT) @(posedge i_clk);
                if (o_tx !== 1'b1) report_problem("host receiver saw a bad stop bit");
                rx_bytes.push_back(b);
            end
        end
    end

    task automatic send_byte(input byte_t b);
        for (int i = 0; i < 10; i++) begin
            if (i == 0) i_rx <= 1'b0;           // start bit
            else if (i == 9) i_rx <= 1'b1;      // stop bit
            else i_rx <= b[i-1];
            repeat (CLKS_PER_BIT) @(posedge i_clk);
        end
    endtask

    task automatic send_word(input word_t w);
        for (int k = 3; k >= 0; k--) send_byte(w[k*8 +: 8]);   // msb first
    endtask

    task automatic wait_halt(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (o_halt !== level && n < limit) begin
            @(posedge i_clk);
            n++;
        end
        if (o_halt !== level) report_problem(what);
    endtask

    task automatic hold_check_halt(input logic level, input int cycles, input string what);
        logic bad;
        bad = 1'b0;
        for (int n = 0; n < cycles; n++) begin
            @(posedge i_clk);
            if (o_halt !== level) bad = 1'b1;
        end
        checks++;
        assert (!bad) else report_problem(what);
    endtask

    task automatic wait_pipe_reset(input int count_before, input string what);
        int n;
        n = 0;
        while (pipe_resets == count_before && n < 2000) begin
            @(posedge i_clk);
            n++;
        end
        if (pipe_resets == count_before) report_problem({"no pipeline reset pulse after ", what});
    endtask

    task automatic fetch_read(input imem_addr_t addr, output word_t data);
        int n;
        n = 0;
        i_fetch_addr <= addr;
        i_fetch_rd   <= 1'b1;
        @(posedge i_clk);
        while (o_fetch_stall && n < 100) begin      // repeat the read while stalled
            @(posedge i_clk);
            n++;
        end
        if (o_fetch_stall) report_problem("fetch read stayed stalled");
        i_fetch_rd <= 1'b0;
        @(posedge i_clk);
        data = o_fetch_data;
    endtask

    // keeps a read of address 0 going until the first load write collides with it
    task automatic watch_write_priority(input word_t expected);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        i_fetch_addr <= '0;
        i_fetch_rd   <= 1'b1;
        while (!seen && n < 3000) begin
            @(posedge i_clk);
            n++;
            if (o_fetch_stall) seen = 1'b1;
        end
        checks++;
        assert (seen) else report_problem("fetch read never met a load write");
        if (seen) begin
            @(posedge i_clk);
            check_value("o_fetch_stall", word_t'(o_fetch_stall), 32'h0);
            i_fetch_rd <= 1'b0;
            @(posedge i_clk);
            check_value("o_fetch_data", o_fetch_data, expected);
        end
        i_fetch_rd <= 1'b0;
    endtask

    task automatic check_dump();
        logic [351:0] frame;
        int           n;
        n = 0;
        while (rx_bytes.size() < DUMP_BYTES && n < 10000) begin
            @(posedge i_clk);
            n++;
        end
        check_value("dump byte count", word_t'(rx_bytes.size()), word_t'(DUMP_BYTES));
        if (rx_bytes.size() == DUMP_BYTES) begin
            frame = {2'b00, latches};   // latches hold still while halted
            for (int i = 0; i < DUMP_BYTES; i++)
                check_value("o_tx byte", {24'h0, rx_bytes[i]}, {24'h0, frame[351-8*i -: 8]});
        end
        rx_bytes.delete();
    endtask

    initial begin : main
        int          base_resets;
        int          base_low;
        word_t       prog [8];
        word_t       got;

        void'($urandom(27));
        i_reset       <= 1'b1;
        i_rx          <= 1'b1;
        i_program_end <= 1'b0;
        i_fetch_addr  <= '0;
        i_fetch_rd    <= 1'b0;
        latches       <= random_latches();
        repeat (16) @(posedge i_clk);
        i_reset <= 1'b0;
        repeat (2) @(posedge i_clk);

        // nothing runs before a program is loaded
        check_value("o_halt", word_t'(o_halt), 32'h1);
        check_value("o_pipe_reset", word_t'(o_pipe_reset), 32'h0);
        send_word(CMD_CONT);
        hold_check_halt(1'b1, 40, "continuous run started without a program");
        send_word(CMD_STEP);
        send_word(CMD_NEXT);    // a step would release halt if the session had opened
        hold_check_halt(1'b1, 40, "step session started without a program");

        // load while a fetch read collides with the first write
        for (int i = 0; i < 8; i++) prog[i] = $urandom;
        base_resets = pipe_resets;
        send_word(CMD_CHARGE);
        fork
            begin
                for (int i = 0; i < 8; i++) send_word(prog[i]);
                send_word(END_INSTR);
            end
            watch_write_priority(prog[0]);
        join
        wait_pipe_reset(base_resets, "program load");
        repeat (4) @(posedge i_clk);
        check_value("o_pipe_reset pulses", word_t'(pipe_resets - base_resets), 32'h1);
        for (int i = 0; i < 8; i++) begin
            fetch_read(imem_addr_t'(i), got);
            check_value("o_fetch_data", got, prog[i]);
        end
        fetch_read(8'd8, got);
        checks++;
        assert (got !== END_INSTR) else report_problem("end marker was written to address 8");

        // continuous run until program end
        base_resets = pipe_resets;
        rx_bytes.delete();
        send_word(CMD_CONT);
        wait_halt(1'b0, 100, "continuous run never released halt");
        hold_check_halt(1'b0, 20, "halt rose before program end");
        i_program_end <= 1'b1;
        wait_halt(1'b1, 10, "halt did not rise after program end");
        check_dump();
        wait_pipe_reset(base_resets, "continuous run");
        repeat (4) @(posedge i_clk);
        check_value("o_pipe_reset pulses", word_t'(pipe_resets - base_resets), 32'h1);
        i_program_end <= 1'b0;

        // step session with two steps and a cancel
        send_word(CMD_STEP);
        step_mode = 1'b1;
        for (int k = 0; k < 2; k++) begin
            base_low = halt_low_cycles;
            send_word(CMD_NEXT);
            check_dump();
            check_value("o_halt low cycles", word_t'(halt_low_cycles - base_low), 32'h1);
        end
        base_resets = pipe_resets;
        base_low    = halt_low_cycles;
        send_word(CMD_CANCEL);
        wait_pipe_reset(base_resets, "step cancel");
        repeat (200) @(posedge i_clk);      // long enough for a dump byte to show up
        check_value("dump byte count", word_t'(rx_bytes.size()), 32'h0);
        check_value("o_halt low cycles", word_t'(halt_low_cycles - base_low), 32'h0);
        check_value("o_pipe_reset pulses", word_t'(pipe_resets - base_resets), 32'h1);
        step_mode = 1'b0;

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (100000) @(posedge i_clk);
        $display("ERROR: simulation did not finish within the cycle limit");
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
dbg_pkg.sv
uart_rx.sv
uart_tx.sv
word_assembler.sv
debug_unit.sv
latch_dumper.sv
imem_arbiter.sv
debug_top.sv
tb_debug_top.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, decide pass or fail from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_debug_top \
    -f files.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_debug_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
    exit 0
fi
exit 1
